// File: project.f
source/snakePkg.sv
source/snakeBody.sv
source/hitCheck.sv
source/drawSequencer.sv
source/snakeGame.sv
verif/snakeGame_assertions.sv
verif/snakeGameTb.sv

// File: Makefile
# Verilator build and run of the snake game testbench

VERILATOR ?= verilator
TOP       ?= snakeGameTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a pass result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/snakeGameTb.sv
`timescale 1ns/1ps

module snakeGameTb;

    import snakePkg::*;

    // upper bound on steps over all tests
    // each reset also pays for the 600 pixel start draw
    localparam int MaxSteps = 60;
    localparam int NumResets = 4;
    localparam int TimeoutCycles = MaxSteps * 250 + NumResets * 700;

    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
        colour_t c;
    } pixel_t;

    logic     Clock;
    logic     reset;
    logic     step;
    heading_t heading;
    colour_t  snakeColour;
    xCoord_t  pixelX;
    yCoord_t  pixelY;
    colour_t  pixelColour;
    logic     plot;
    logic     busy;
    logic     gameOver;

    // expected plot triples in arrival order
    pixel_t expectQ[$];

    // model copy of the body with segment 0 as the head
    int modelX [SnakeLength];
    int modelY [SnakeLength];

    string       testName;
    logic        over;
    logic        hit;
    logic [1:0]  pick;

    snakeGame UUT (
        .Clock       (Clock),
        .reset       (reset),
        .step        (step),
        .heading     (heading),
        .snakeColour (snakeColour),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .pixelColour (pixelColour),
        .plot        (plot),
        .busy        (busy),
        .gameOver    (gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkX(input string what, input xCoord_t expected, input xCoord_t actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                testName, what, expected, actual));
        end
    endtask

    task automatic checkY(input string what, input yCoord_t expected, input yCoord_t actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                testName, what, expected, actual));
        end
    endtask

    task automatic checkColour(input string what, input colour_t expected,
                               input colour_t actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                testName, what, expected, actual));
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("[ERROR] %s %s: expected %0b, actual %0b",
                testName, what, expected, actual));
        end
    endtask

    // one 10x10 block in row-major order with x fastest
    function automatic void pushBlock(input int originX, input int originY, input colour_t c);
        pixel_t p;
        for (int y = 0; y < BlockSize; y++)
        begin
            for (int x = 0; x < BlockSize; x++)
            begin
                p.x = xCoord_t'(originX + x);
                p.y = yCoord_t'(originY + y);
                p.c = c;
                expectQ.push_back(p);
            end
        end
    endfunction

    // start column below the head
    function automatic void modelReset();
        for (int k = 0; k < SnakeLength; k++)
        begin
            modelX[k] = 80;
            modelY[k] = 60 + k * BlockSize;
        end
    endfunction

    // reference move that returns the expected collision and queues the plots
    function automatic logic modelStep(input heading_t h);
        int   nx;
        int   ny;
        logic collision;
        nx = modelX[0];
        ny = modelY[0];
        case (h)
            headLeft:  nx = nx - BlockSize;
            headRight: nx = nx + BlockSize;
            headUp:    ny = ny - BlockSize;
            headDown:  ny = ny + BlockSize;
        endcase
        // signed ints go negative past the top or left wall
        collision = (nx < 0) || (ny < 0) || (nx > ScreenWidth - BlockSize)
            || (ny > ScreenHeight - BlockSize);
        // tail excluded since it leaves its block on this move
        for (int k = 0; k < SnakeLength - 1; k++)
        begin
            if ((nx == modelX[k]) && (ny == modelY[k]))
            begin
                collision = 1'b1;
            end
        end
        if (!collision)
        begin
            pushBlock(modelX[SnakeLength-1], modelY[SnakeLength-1], 3'b000);
            for (int k = SnakeLength - 1; k > 0; k--)
            begin
                modelX[k] = modelX[k-1];
                modelY[k] = modelY[k-1];
            end
            modelX[0] = nx;
            modelY[0] = ny;
            pushBlock(nx, ny, snakeColour);
        end
        return collision;
    endfunction

    // every plot pops one expected pixel
    always @(posedge Clock)
    begin : comparePlots
        pixel_t expected;
        if (!reset && plot)
        begin
            if (expectQ.size() == 0)
            begin
                abortRun($sformatf("unexpected plot at x=%0d y=%0d during test %s",
                    pixelX, pixelY, testName));
            end
            else
            begin
                expected = expectQ.pop_front();
                checkX("pixelX", expected.x, pixelX);
                checkY("pixelY", expected.y, pixelY);
                checkColour("pixelColour", expected.c, pixelColour);
            end
        end
    end

    // hard limit on the whole run
    initial
    begin
        repeat (TimeoutCycles) @(posedge Clock);
        abortRun("timeout: the tests did not finish within the allowed number of cycles");
    end

    task automatic checkDrained();
        if (expectQ.size() != 0)
        begin
            abortRun($sformatf("%0d expected pixels were never plotted in test %s",
                expectQ.size(), testName));
        end
    endtask

    task automatic waitIdle();
        while (busy)
        begin
            @(negedge Clock);
        end
    endtask

    // single-cycle strobe started on a falling edge
    task automatic pulseStep(input heading_t h);
        step = 1'b1;
        heading = h;
        @(negedge Clock);
        step = 1'b0;
    endtask

    task automatic applyReset(input string name);
        testName = name;
        reset = 1'b1;
        step = 1'b0;
        snakeColour = colour_t'($urandom_range(7, 1));
        expectQ.delete();
        modelReset();
        repeat (5) @(negedge Clock);
        reset = 1'b0;
        for (int k = 0; k < SnakeLength; k++)
        begin
            pushBlock(modelX[k], modelY[k], snakeColour);
        end
        checkFlag("busy after reset", 1'b1, busy);
        waitIdle();
        checkDrained();
        checkFlag("gameOver after reset", 1'b0, gameOver);
    endtask

    task automatic runStep(input heading_t h, output logic collision);
        collision = modelStep(h);
        pulseStep(h);
        checkFlag("busy after step", 1'b1, busy);
        waitIdle();
        checkFlag("gameOver", collision, gameOver);
        checkDrained();
    endtask

    // strobe after the game has ended must change nothing
    task automatic pulseAfterEnd(input heading_t h);
        pulseStep(h);
        repeat (4) @(negedge Clock);
        checkFlag("busy after end", 1'b0, busy);
        checkFlag("gameOver held", 1'b1, gameOver);
        checkDrained();
    endtask

    initial
    begin
        void'($urandom(32'hc0ba));
        reset = 1'b1;
        step = 1'b0;
        heading = headUp;
        snakeColour = 3'b010;
        @(negedge Clock);
        applyReset("initialDraw");

        testName = "simpleMoves";
        runStep(headLeft, over);
        runStep(headUp, over);
        runStep(headRight, over);

        // second strobe lands mid-sweep as a reverse that would hit the body
        testName = "ignoredSteps";
        hit = modelStep(headUp);
        pulseStep(headUp);
        repeat ($urandom_range(150, 10)) @(negedge Clock);
        pulseStep(headDown);
        waitIdle();
        checkFlag("gameOver", hit, gameOver);
        checkDrained();
        runStep(headLeft, over);

        // six moves reach the top row and the seventh leaves the screen
        applyReset("wallCollision");
        for (int i = 0; i < 7; i++)
        begin
            runStep(headUp, over);
        end
        checkFlag("gameOver at wall", 1'b1, gameOver);
        pulseAfterEnd(headLeft);
        pulseAfterEnd(headRight);

        applyReset("selfCollision");
        runStep(headDown, over);
        checkFlag("gameOver into body", 1'b1, gameOver);

        applyReset("randomWalk");
        over = 1'b0;
        for (int i = 0; (i < 40) && !over; i++)
        begin
            repeat ($urandom_range(5, 0)) @(negedge Clock);
            pick = 2'($urandom_range(3, 0));
            runStep(heading_t'(pick), over);
        end

        repeat (2) @(negedge Clock);
        if (expectQ.size() == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            abortRun("expected pixels were still queued at the end of the run");
        end
    end

endmodule

// File: verif/snakeGame_assertions.sv
`timescale 1ns/1ps

module snakeGame_assertions (
    input logic Clock,
    input logic reset,
    input logic plot,
    input logic busy,
    input logic gameOver
);

    // pixels only go out during a sweep
    plotNeedsBusy: assert property (
        @(posedge Clock) disable iff (reset) plot |-> busy
    ) else $error("plot high while busy is low");

    // ended is left only through reset
    gameOverSticky: assert property (
        @(posedge Clock) disable iff (reset) $past(gameOver) |-> gameOver
    ) else $error("gameOver fell without reset");

    // nothing drawn once the game is over
    noPlotWhenOver: assert property (
        @(posedge Clock) disable iff (reset) gameOver |-> !plot
    ) else $error("plot high while gameOver is high");

endmodule

bind snakeGame snakeGame_assertions protocolChecks (
    .Clock    (Clock),
    .reset    (reset),
    .plot     (plot),
    .busy     (busy),
    .gameOver (gameOver)
);

// File: source/snakeGame.sv
`timescale 1ns/1ps

module snakeGame (
    input  logic               Clock,
    input  logic               reset,
    input  logic               step,
    input  snakePkg::heading_t heading,
    input  snakePkg::colour_t  snakeColour,
    output snakePkg::xCoord_t  pixelX,
    output snakePkg::yCoord_t  pixelY,
    output snakePkg::colour_t  pixelColour,
    output logic               plot,
    output logic               busy,
    output logic               gameOver
);

    import snakePkg::*;

    // strobes from the sequencer into the body store
    logic latchHeading;
    logic advance;
    logic collide;

    xCoord_t nextHeadX;
    yCoord_t nextHeadY;
    xCoord_t tailX;
    yCoord_t tailY;

    // full body, shared by the collision test and the sweeps
    xCoord_t segX [SnakeLength];
    yCoord_t segY [SnakeLength];

    snakeBody body (
        .Clock        (Clock),
        .reset        (reset),
        .latchHeading (latchHeading),
        .advance      (advance),
        .heading      (heading),
        .nextHeadX    (nextHeadX),
        .nextHeadY    (nextHeadY),
        .segX         (segX),
        .segY         (segY),
        .tailX        (tailX),
        .tailY        (tailY)
    );

    // same head proposal as the body store, no added latency
    hitCheck hit (
        .nextHeadX (nextHeadX),
        .nextHeadY (nextHeadY),
        .segX      (segX),
        .segY      (segY),
        .collide   (collide)
    );

    drawSequencer sequencer (
        .Clock        (Clock),
        .reset        (reset),
        .step         (step),
        .collide      (collide),
        .segX         (segX),
        .segY         (segY),
        .tailX        (tailX),
        .tailY        (tailY),
        .snakeColour  (snakeColour),
        .latchHeading (latchHeading),
        .advance      (advance),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .pixelColour  (pixelColour),
        .plot         (plot),
        .busy         (busy),
        .gameOver     (gameOver)
    );

endmodule

// File: source/drawSequencer.sv
`timescale 1ns/1ps

module drawSequencer (
    input  logic              Clock,
    input  logic              reset,
    input  logic              step,
    input  logic              collide,
    input  snakePkg::xCoord_t segX [snakePkg::SnakeLength],
    input  snakePkg::yCoord_t segY [snakePkg::SnakeLength],
    input  snakePkg::xCoord_t tailX,
    input  snakePkg::yCoord_t tailY,
    input  snakePkg::colour_t snakeColour,
    output logic              latchHeading,
    output logic              advance,
    output snakePkg::xCoord_t pixelX,
    output snakePkg::yCoord_t pixelY,
    output snakePkg::colour_t pixelColour,
    output logic              plot,
    output logic              busy,
    output logic              gameOver
);

    import snakePkg::*;

    drawState_t state;
    drawState_t nextState;

    // block being drawn during the initial sweep
    segIndex_t segIndex;

    // pixel position inside the current block
    blockCount_t countX;
    blockCount_t countY;

    // old tail, held because advance moves it before the erase
    xCoord_t eraseX;
    yCoord_t eraseY;

    // origin of the block being swept
    xCoord_t originX;
    yCoord_t originY;

    logic sweeping;
    logic blockDone;

    assign sweeping = (state == drawInit) || (state == eraseTail) || (state == drawHead);
    assign blockDone = (countX == BlockLast) && (countY == BlockLast);

    // step taken only in idle, so never while busy or after game over
    assign latchHeading = (state == idle) && step;
    assign advance = (state == checkMove) && !collide;

    always_comb
    begin
        nextState = state;
        case (state)
            drawInit:
                if (blockDone && (segIndex == LastSeg))
                    nextState = idle;
            idle:
                if (step)
                    nextState = checkMove;
            checkMove:
                nextState = collide ? ended : eraseTail;
            eraseTail:
                if (blockDone)
                    nextState = drawHead;
            drawHead:
                if (blockDone)
                    nextState = idle;
            ended:
                nextState = ended;
            default:
                nextState = drawInit;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= drawInit;
            segIndex <= '0;
            countX <= '0;
            countY <= '0;
        end
        else
        begin
            state <= nextState;
            // row-major sweep, x runs fastest
            if (sweeping)
            begin
                if (countX == BlockLast)
                begin
                    countX <= '0;
                    countY <= (countY == BlockLast) ? '0 : countY + 1'b1;
                end
                else
                begin
                    countX <= countX + 1'b1;
                end
            end
            else
            begin
                countX <= '0;
                countY <= '0;
            end
            // next segment once a start block is finished
            if ((state == drawInit) && blockDone && (segIndex != LastSeg))
            begin
                segIndex <= segIndex + 1'b1;
            end
        end
    end

    // tail taken on the same edge that shifts the body
    always_ff @(posedge Clock)
    begin
        if (advance)
        begin
            eraseX <= tailX;
            eraseY <= tailY;
        end
    end

    always_comb
    begin
        case (state)
            drawInit:
            begin
                originX = segX[segIndex];
                originY = segY[segIndex];
            end
            eraseTail:
            begin
                originX = eraseX;
                originY = eraseY;
            end
            default:
            begin
                // new head once the body has moved
                originX = segX[0];
                originY = segY[0];
            end
        endcase
    end

    assign pixelX = originX + xCoord_t'(countX);
    assign pixelY = originY + yCoord_t'(countY);
    assign pixelColour = (state == eraseTail) ? EraseColour : snakeColour;

    // one plotted pixel per sweep cycle
    assign plot = sweeping;
    assign busy = (state != idle) && (state != ended);
    assign gameOver = (state == ended);

endmodule

// File: source/hitCheck.sv
`timescale 1ns/1ps

module hitCheck (
    input  snakePkg::xCoord_t nextHeadX,
    input  snakePkg::yCoord_t nextHeadY,
    input  snakePkg::xCoord_t segX [snakePkg::SnakeLength],
    input  snakePkg::yCoord_t segY [snakePkg::SnakeLength],
    output logic              collide
);

    import snakePkg::*;

    logic wallHit;
    logic bodyHit;

    // unsigned wrap turns a move past 0 into a value above the max
    // so one upper bound per axis covers both walls
    assign wallHit = (nextHeadX > MaxHeadX) || (nextHeadY > MaxHeadY);

    // blocks are grid aligned, equal origins mean overlap
    always_comb
    begin
        bodyHit = 1'b0;
        // tail left out, it moves off its block on the same step
        for (int k = 0; k < SnakeLength - 1; k++)
        begin
            if ((nextHeadX == segX[k]) && (nextHeadY == segY[k]))
            begin
                bodyHit = 1'b1;
            end
        end
    end

    // either cause ends the game
    assign collide = wallHit || bodyHit;

endmodule

// File: source/snakeBody.sv
`timescale 1ns/1ps

module snakeBody (
    input  logic               Clock,
    input  logic               reset,
    input  logic               latchHeading,
    input  logic               advance,
    input  snakePkg::heading_t heading,
    output snakePkg::xCoord_t  nextHeadX,
    output snakePkg::yCoord_t  nextHeadY,
    output snakePkg::xCoord_t  segX [snakePkg::SnakeLength],
    output snakePkg::yCoord_t  segY [snakePkg::SnakeLength],
    output snakePkg::xCoord_t  tailX,
    output snakePkg::yCoord_t  tailY
);

    import snakePkg::*;

    // heading captured at step acceptance
    heading_t headingReg;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            headingReg <= headUp;
        end
        else if (latchHeading)
        begin
            headingReg <= heading;
        end
    end

    // segment 0 is the head, last entry is the tail
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // start column, one block apart going down
            for (int k = 0; k < SnakeLength; k++)
            begin
                segX[k] <= StartX;
                segY[k] <= StartY + yCoord_t'(k * BlockSize);
            end
        end
        else if (advance)
        begin
            // every segment takes the place of the one ahead of it
            for (int k = SnakeLength - 1; k > 0; k--)
            begin
                segX[k] <= segX[k-1];
                segY[k] <= segY[k-1];
            end
            segX[0] <= nextHeadX;
            segY[0] <= nextHeadY;
        end
    end

    // proposed head, a move off the low edge wraps to a large value
    always_comb
    begin
        nextHeadX = segX[0];
        nextHeadY = segY[0];
        case (headingReg)
            headLeft:  nextHeadX = segX[0] - StepX;
            headRight: nextHeadX = segX[0] + StepX;
            headUp:    nextHeadY = segY[0] - StepY;
            headDown:  nextHeadY = segY[0] + StepY;
            default:   nextHeadY = segY[0];
        endcase
    end

    assign tailX = segX[SnakeLength-1];
    assign tailY = segY[SnakeLength-1];

endmodule

// File: source/snakePkg.sv
package snakePkg;

    // screen grid in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    // side of one square snake block
    localparam int BlockSize = 10;

    // fixed snake length in blocks
    localparam int SnakeLength = 6;

    // width of the segment index used by the initial draw
    localparam int SegIndexWidth = $clog2(SnakeLength);

    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;
    typedef logic [2:0] colour_t;

    // pixel counter inside one block sweep
    typedef logic [3:0] blockCount_t;

    typedef logic [SegIndexWidth-1:0] segIndex_t;

    // head start point, body hangs below it in one column
    localparam xCoord_t StartX = 8'd80;
    localparam yCoord_t StartY = 7'd60;

    // background colour used to erase the tail
    localparam colour_t EraseColour = 3'b000;

    // per-axis step of one block move
    localparam xCoord_t StepX = xCoord_t'(BlockSize);
    localparam yCoord_t StepY = yCoord_t'(BlockSize);

    // highest legal block origin on each axis
    localparam xCoord_t MaxHeadX = xCoord_t'(ScreenWidth - BlockSize);
    localparam yCoord_t MaxHeadY = yCoord_t'(ScreenHeight - BlockSize);

    // last counter value inside a block and last segment index
    localparam blockCount_t BlockLast = blockCount_t'(BlockSize - 1);
    localparam segIndex_t LastSeg = segIndex_t'(SnakeLength - 1);

    typedef enum logic [1:0] {
        headLeft,
        headUp,
        headDown,
        headRight
    } heading_t;

    typedef enum logic [2:0] {
        drawInit,
        idle,
        checkMove,
        eraseTail,
        drawHead,
        ended
    } drawState_t;

endpackage
